// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // ########################################################
    // basic word and index types.
    // ########################################################

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    // width of a load or store access.
    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } byte_type_t;

    // ########################################################
    // data cache geometry.
    // ########################################################

    localparam int DCACHE_LINES = 16;
    localparam int MEM_WORDS    = 256;
    localparam int MISS_CYCLES  = 4;

    // the cache has one word per line, so the index sits right above the byte offset.
    localparam int DCACHE_IDX_W = $clog2(DCACHE_LINES);
    localparam int MEM_ADDR_W   = $clog2(MEM_WORDS);
    localparam int DCACHE_TAG_W = MEM_ADDR_W - DCACHE_IDX_W;
    localparam int MISS_CNT_W   = $clog2(MISS_CYCLES);

endpackage

// File: rtl/pipe_pkg.sv
package pipe_pkg;

    // ########################################################
    // stage to stage passes.
    // ########################################################

    typedef struct packed {
        cpu_pkg::u32_t       pc;
        cpu_pkg::u32_t       ex_out;
        cpu_pkg::u32_t       store_data;
        logic                is_mem;
        logic                is_store;
        cpu_pkg::byte_type_t byte_type;
        logic                is_signed;
        logic                is_wr_rd;
        logic                is_wr_rd_pc_plus4;
        cpu_pkg::u32_t       pc_plus4;
        cpu_pkg::reg_idx_t   rd;
        logic                is_wr_csr;
        cpu_pkg::csr_addr_t  csr_addr;
        logic                is_flush;
    } execute_memory1_pass_t;

    // byte_en holds the address low bits that pick the lane of a load.
    typedef struct packed {
        cpu_pkg::u32_t       pc;
        cpu_pkg::u32_t       ex_out;
        logic                is_mem;
        cpu_pkg::byte_type_t byte_type;
        logic                is_signed;
        logic                is_wr_rd;
        logic                is_wr_rd_pc_plus4;
        cpu_pkg::u32_t       pc_plus4;
        cpu_pkg::reg_idx_t   rd;
        logic                is_wr_csr;
        cpu_pkg::csr_addr_t  csr_addr;
        logic [1:0]          byte_en;
        logic                is_flush;
    } memory1_memory2_pass_t;

    typedef struct packed {
        cpu_pkg::u32_t      pc;
        cpu_pkg::u32_t      ex_mem_out;
        logic               is_wr_rd;
        logic               is_wr_rd_pc_plus4;
        cpu_pkg::reg_idx_t  rd;
        logic               is_wr_csr;
        cpu_pkg::csr_addr_t csr_addr;
        logic               is_flush;
    } memory2_writeback_pass_t;

    typedef struct packed {
        logic          valid;
        logic [3:0]    cause;
        cpu_pkg::u32_t tval;
    } excp_pass_t;

    // ########################################################
    // side channels.
    // ########################################################

    typedef struct packed {
        logic              valid;
        cpu_pkg::reg_idx_t idx;
        cpu_pkg::u32_t     data;
    } forward_req_t;

    typedef struct packed {
        logic          valid;
        logic          we;
        cpu_pkg::u32_t addr;
        cpu_pkg::u32_t wdata;
        logic [3:0]    wstrb;
    } dcache_req_t;

endpackage

// File: rtl/memory1.sv
`timescale 1ns/1ps

module memory1 (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            is_stall,
    input  logic                            is_flush,
    input  pipe_pkg::execute_memory1_pass_t pass_in,
    input  pipe_pkg::excp_pass_t            excp_pass_in,
    output pipe_pkg::dcache_req_t           dcache_req,
    output pipe_pkg::memory1_memory2_pass_t pass_out,
    output pipe_pkg::excp_pass_t            excp_pass_out
);
    import cpu_pkg::*;
    import pipe_pkg::*;

    execute_memory1_pass_t pass_r;
    excp_pass_t            excp_r;
    logic                  kill;
    logic [1:0]            lane;
    logic [3:0]            wstrb;
    u32_t                  wdata;

    // an instruction accepted together with a flush enters as a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid <= 1'b0;
        end else if (!is_stall) begin
            pass_r <= pass_in;
            pass_r.is_flush <= pass_in.is_flush | is_flush;
            excp_r <= excp_pass_in;
        end
    end

    assign kill = pass_r.is_flush | is_flush;
    assign lane = pass_r.ex_out[1:0];

    // store data is moved onto the lanes that the strobe enables.
    always_comb begin
        case (pass_r.byte_type)
            BYTE: begin
                wstrb = 4'b0001 << lane;
                wdata = {24'b0, pass_r.store_data[7:0]} << {lane, 3'b000};
            end
            HALF_WORD: begin
                wstrb = 4'b0011 << {lane[1], 1'b0};
                wdata = {16'b0, pass_r.store_data[15:0]} << {lane[1], 4'b0000};
            end
            default: begin
                wstrb = 4'b1111;
                wdata = pass_r.store_data;
            end
        endcase
    end

    assign dcache_req.valid = pass_r.is_mem & ~kill;
    assign dcache_req.we    = pass_r.is_store;
    assign dcache_req.addr  = pass_r.ex_out;
    assign dcache_req.wdata = wdata;
    assign dcache_req.wstrb = wstrb;

    assign pass_out.pc                = pass_r.pc;
    assign pass_out.ex_out            = pass_r.ex_out;
    assign pass_out.is_mem            = pass_r.is_mem;
    assign pass_out.byte_type         = pass_r.byte_type;
    assign pass_out.is_signed         = pass_r.is_signed;
    assign pass_out.is_wr_rd          = pass_r.is_wr_rd;
    assign pass_out.is_wr_rd_pc_plus4 = pass_r.is_wr_rd_pc_plus4;
    assign pass_out.pc_plus4          = pass_r.pc_plus4;
    assign pass_out.rd                = pass_r.rd;
    assign pass_out.is_wr_csr         = pass_r.is_wr_csr;
    assign pass_out.csr_addr          = pass_r.csr_addr;
    assign pass_out.byte_en           = lane;
    assign pass_out.is_flush          = kill;

    assign excp_pass_out = excp_r;

endmodule

// File: rtl/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold,
    input  pipe_pkg::dcache_req_t req,
    output logic                  ready,
    output cpu_pkg::u32_t         data
);
    import cpu_pkg::*;
    import pipe_pkg::*;

    logic [DCACHE_TAG_W-1:0] tag_q [DCACHE_LINES];
    u32_t                    line_q [DCACHE_LINES];
    logic [DCACHE_LINES-1:0] line_vld_q;
    u32_t                    mem_q [MEM_WORDS] = '{default: '0};

    dcache_req_t             pend_q;
    dcache_req_t             cur;
    logic                    busy_q;
    logic [MISS_CNT_W-1:0]   cnt_q;
    logic                    ready_q;
    u32_t                    data_q;

    logic [DCACHE_IDX_W-1:0] idx;
    logic [DCACHE_TAG_W-1:0] tag;
    logic [MEM_ADDR_W-1:0]   widx;
    logic                    hit;
    logic                    accept;
    logic                    complete;
    u32_t                    merged;

    function automatic u32_t merge_word(u32_t old, u32_t wdata, logic [3:0] wstrb);
        u32_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // while a miss is pending the captured request is the one being served.
    assign cur  = busy_q ? pend_q : req;
    assign idx  = cur.addr[2 +: DCACHE_IDX_W];
    assign tag  = cur.addr[2 + DCACHE_IDX_W +: DCACHE_TAG_W];
    assign widx = cur.addr[2 +: MEM_ADDR_W];
    assign hit  = line_vld_q[idx] & (tag_q[idx] == tag);

    assign accept   = ~busy_q & ~hold & req.valid;
    assign complete = busy_q ? (cnt_q == '0) : (accept & hit);
    assign merged   = merge_word(mem_q[widx], cur.wdata, cur.wstrb);

    // ########################################################
    // miss counter and line valid bits.
    // ########################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
            ready_q <= 1'b0;
            line_vld_q <= '0;
        end else begin
            if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                busy_q <= (cnt_q != '0);
            end else if (accept && !hit) begin
                busy_q <= 1'b1;
                cnt_q <= MISS_CNT_W'(MISS_CYCLES - 1);
            end
            if (busy_q || !hold) begin
                ready_q <= complete;
            end
            if (complete && !cur.we && !hit) begin
                line_vld_q[idx] <= 1'b1;
            end
        end
    end

    // ########################################################
    // arrays and response data.
    // ########################################################

    // stores write through and never allocate a line.
    always_ff @(posedge clk) begin
        if (complete) begin
            if (cur.we) begin
                mem_q[widx] <= merged;
                data_q <= merged;
                if (hit) begin
                    line_q[idx] <= merged;
                end
            end else begin
                data_q <= hit ? line_q[idx] : mem_q[widx];
                if (!hit) begin
                    line_q[idx] <= mem_q[widx];
                    tag_q[idx] <= tag;
                end
            end
        end
        if (accept) begin
            pend_q <= req;
        end
    end

    assign ready = ready_q;
    assign data  = data_q;

endmodule

// File: rtl/memory2.sv
`timescale 1ns/1ps

module memory2 (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              is_stall,
    input  logic                              is_flush,
    input  pipe_pkg::memory1_memory2_pass_t   pass_in,
    input  pipe_pkg::excp_pass_t              excp_pass_in,
    input  logic                              dcache_ready,
    input  cpu_pkg::u32_t                     dcache_data,
    output pipe_pkg::forward_req_t            fwd_req,
    output logic                              dcache_stall,
    output pipe_pkg::memory2_writeback_pass_t pass_out,
    output pipe_pkg::excp_pass_t              excp_pass_out
);
    import cpu_pkg::*;
    import pipe_pkg::*;

    memory1_memory2_pass_t pass_r;
    excp_pass_t            excp_r;
    logic                  kill;
    logic [7:0]            mem_byte;
    logic [15:0]           mem_half;
    u32_t                  mem_out;
    u32_t                  rd_data;
    u32_t                  ex_mem_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid <= 1'b0;
        end else if (!is_stall) begin
            pass_r <= pass_in;
            excp_r <= excp_pass_in;
        end
    end

    assign kill = is_flush | pass_r.is_flush;

    // register result of a non-load. loads forward ex_out as well.
    assign rd_data = pass_r.is_wr_rd_pc_plus4 ? pass_r.pc_plus4 : pass_r.ex_out;

    assign fwd_req.valid = pass_r.is_wr_rd & ~kill;
    assign fwd_req.idx   = pass_r.rd;
    assign fwd_req.data  = rd_data;

    // ########################################################
    // load data extraction.
    // ########################################################

    always_comb begin
        case (pass_r.byte_en)
            2'b00:   mem_byte = dcache_data[7:0];
            2'b01:   mem_byte = dcache_data[15:8];
            2'b10:   mem_byte = dcache_data[23:16];
            default: mem_byte = dcache_data[31:24];
        endcase
    end

    assign mem_half = pass_r.byte_en[1] ? dcache_data[31:16] : dcache_data[15:0];

    always_comb begin
        case (pass_r.byte_type)
            BYTE:      mem_out = {{24{pass_r.is_signed & mem_byte[7]}}, mem_byte};
            HALF_WORD: mem_out = {{16{pass_r.is_signed & mem_half[15]}}, mem_half};
            default:   mem_out = dcache_data;
        endcase
    end

    assign ex_mem_out = pass_r.is_mem ? mem_out : rd_data;

    // a flushed access still waits for its response so the cache stays in step.
    assign dcache_stall = pass_r.is_mem & ~pass_r.is_flush & ~dcache_ready;

    assign pass_out.pc                = pass_r.pc;
    assign pass_out.ex_mem_out        = ex_mem_out;
    assign pass_out.is_wr_rd          = pass_r.is_wr_rd;
    assign pass_out.is_wr_rd_pc_plus4 = pass_r.is_wr_rd_pc_plus4;
    assign pass_out.rd                = pass_r.rd;
    assign pass_out.is_wr_csr         = pass_r.is_wr_csr;
    assign pass_out.csr_addr          = pass_r.csr_addr;
    assign pass_out.is_flush          = kill;

    assign excp_pass_out = excp_r;

endmodule

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              is_flush,
    input  pipe_pkg::execute_memory1_pass_t   ex_pass,
    input  pipe_pkg::excp_pass_t              excp_in,
    output pipe_pkg::memory2_writeback_pass_t wb_pass,
    output pipe_pkg::excp_pass_t              excp_out,
    output pipe_pkg::forward_req_t            fwd_req,
    output logic                              stall
);
    import cpu_pkg::*;
    import pipe_pkg::*;

    memory1_memory2_pass_t mem1_pass;
    excp_pass_t            mem1_excp;
    dcache_req_t           dcache_req;
    logic                  dcache_ready;
    u32_t                  dcache_data;

    // the cache stall from memory2 freezes every stage register and the cache.
    memory1 u_memory1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .is_stall      (stall),
        .is_flush      (is_flush),
        .pass_in       (ex_pass),
        .excp_pass_in  (excp_in),
        .dcache_req    (dcache_req),
        .pass_out      (mem1_pass),
        .excp_pass_out (mem1_excp)
    );

    dcache u_dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (stall),
        .req   (dcache_req),
        .ready (dcache_ready),
        .data  (dcache_data)
    );

    memory2 u_memory2 (
        .clk           (clk),
        .rst_n         (rst_n),
        .is_stall      (stall),
        .is_flush      (is_flush),
        .pass_in       (mem1_pass),
        .excp_pass_in  (mem1_excp),
        .dcache_ready  (dcache_ready),
        .dcache_data   (dcache_data),
        .fwd_req       (fwd_req),
        .dcache_stall  (stall),
        .pass_out      (wb_pass),
        .excp_pass_out (excp_out)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset is held for ten rising edges and released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verif/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import cpu_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = NUM_INSTR * (2 + MISS_CYCLES) + 100;

    typedef struct {
        memory2_writeback_pass_t wb;
        logic                    check_data;
        logic                    is_mem;
        logic                    no_stall;
        u32_t                    fwd_data;
        excp_pass_t              excp;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    logic                    is_flush;
    execute_memory1_pass_t   ex_pass;
    excp_pass_t              excp_in;
    memory2_writeback_pass_t wb_pass;
    excp_pass_t              excp_out;
    forward_req_t            fwd_req;
    logic                    stall;

    integer  seed;
    u32_t    model [MEM_WORDS];
    expect_t exp_q [$];
    int      issued;
    int      stall_cnt;
    int      cycles;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_stage_top u_mem_stage_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_flush (is_flush),
        .ex_pass  (ex_pass),
        .excp_in  (excp_in),
        .wb_pass  (wb_pass),
        .excp_out (excp_out),
        .fwd_req  (fwd_req),
        .stall    (stall)
    );

    // ############################################################
    // failure reporting and checks.
    // ############################################################

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input u32_t exp, input u32_t act);
        assert (act === exp) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error: %s", what);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // outputs are sampled on the falling edge, where they are stable.
    task automatic check_outputs();
        expect_t e;
        if (issued == 0) begin
            check_true(!stall, "stall is active before any instruction");
            check_true(!fwd_req.valid, "forward request is active before any instruction");
            check_true(wb_pass.is_flush, "writeback is valid before any instruction");
        end
        if (stall) begin
            check_true(exp_q.size() > 0 && exp_q[0].is_mem,
                       "stall is high with no memory access in the second stage");
            stall_cnt++;
        end
        if (fwd_req.valid) begin
            check_true(!wb_pass.is_flush, "forward request while the second stage is empty");
            check_true(exp_q.size() > 0, "forward request with no instruction in flight");
            check_value("fwd_req.idx", u32_t'(exp_q[0].wb.rd), u32_t'(fwd_req.idx));
            check_value("fwd_req.data", exp_q[0].fwd_data, fwd_req.data);
        end
        if (!wb_pass.is_flush && !stall) begin
            check_true(exp_q.size() > 0, "writeback output with no instruction expected");
            e = exp_q.pop_front();
            check_value("wb_pass.pc", e.wb.pc, wb_pass.pc);
            if (e.check_data) begin
                check_value("wb_pass.ex_mem_out", e.wb.ex_mem_out, wb_pass.ex_mem_out);
            end
            check_value("wb_pass.is_wr_rd", u32_t'(e.wb.is_wr_rd), u32_t'(wb_pass.is_wr_rd));
            check_value("wb_pass.is_wr_rd_pc_plus4", u32_t'(e.wb.is_wr_rd_pc_plus4),
                        u32_t'(wb_pass.is_wr_rd_pc_plus4));
            check_value("wb_pass.rd", u32_t'(e.wb.rd), u32_t'(wb_pass.rd));
            check_value("wb_pass.is_wr_csr", u32_t'(e.wb.is_wr_csr), u32_t'(wb_pass.is_wr_csr));
            check_value("wb_pass.csr_addr", u32_t'(e.wb.csr_addr), u32_t'(wb_pass.csr_addr));
            check_value("fwd_req.valid", u32_t'(e.wb.is_wr_rd), u32_t'(fwd_req.valid));
            check_value("excp_out.valid_cause", u32_t'({e.excp.valid, e.excp.cause}),
                        u32_t'({excp_out.valid, excp_out.cause}));
            check_value("excp_out.tval", e.excp.tval, excp_out.tval);
            if (e.no_stall) begin
                check_value("stall cycles of repeated load", 32'h0, u32_t'(stall_cnt));
            end
            stall_cnt = 0;
        end
    endtask

    // ############################################################
    // reference memory and stimulus.
    // ############################################################

    function automatic u32_t rand_word();
        return u32_t'($random(seed));
    endfunction

    function automatic u32_t load_value(input u32_t addr, input byte_type_t bt, input logic sgn);
        u32_t       word;
        logic [7:0] b;
        logic [15:0] h;
        word = model[addr[2 +: MEM_ADDR_W]];
        b = word[8 * addr[1:0] +: 8];
        h = addr[1] ? word[31:16] : word[15:0];
        case (bt)
            BYTE:      return {{24{sgn & b[7]}}, b};
            HALF_WORD: return {{16{sgn & h[15]}}, h};
            default:   return word;
        endcase
    endfunction

    task automatic apply_store(input u32_t addr, input byte_type_t bt, input u32_t data);
        u32_t word;
        word = model[addr[2 +: MEM_ADDR_W]];
        case (bt)
            BYTE:      word[8 * addr[1:0] +: 8] = data[7:0];
            HALF_WORD: word[16 * addr[1] +: 16] = data[15:0];
            default:   word = data;
        endcase
        model[addr[2 +: MEM_ADDR_W]] = word;
    endtask

    task automatic rand_access(output u32_t addr, output byte_type_t bt);
        u32_t r;
        u32_t w;
        r = rand_word();
        w = rand_word();
        case (r[1:0])
            2'b00:   bt = BYTE;
            2'b01:   bt = HALF_WORD;
            default: bt = WORD;
        endcase
        addr = u32_t'(w[MEM_ADDR_W-1:0]) << 2;
        if (bt == BYTE) begin
            addr[1:0] = w[9:8];
        end else if (bt == HALF_WORD) begin
            addr[1] = w[8];
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle();
        next_cycle();
        ex_pass = '0;
        ex_pass.is_flush = 1'b1;
        is_flush = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (exp_q.size() != 0) begin
            idle();
        end
    endtask

    // an instruction driven while stall is low is taken at the next rising edge.
    task automatic send(input execute_memory1_pass_t p, input expect_t e, input logic flush);
        excp_pass_t x;
        expect_t    ent;
        u32_t       r;
        next_cycle();
        while (stall) begin
            next_cycle();
        end
        r = rand_word();
        x.valid = r[0];
        x.cause = r[7:4];
        x.tval = rand_word();
        ex_pass = p;
        excp_in = x;
        is_flush = flush;
        ent = e;
        ent.excp = x;
        if (!flush) begin
            exp_q.push_back(ent);
        end
        issued++;
    endtask

    task automatic issue_mem(input logic store, input u32_t addr, input byte_type_t bt,
                             input logic flush, input logic no_stall);
        execute_memory1_pass_t p;
        expect_t               e;
        u32_t                  r;
        r = rand_word();
        p = '0;
        p.pc = rand_word() & 32'hffff_fffc;
        p.pc_plus4 = p.pc + 32'd4;
        p.ex_out = addr;
        p.store_data = rand_word();
        p.is_mem = 1'b1;
        p.is_store = store;
        p.byte_type = bt;
        p.is_signed = r[0];
        p.is_wr_rd = ~store;
        p.rd = r[12:8];
        p.csr_addr = r[27:16];
        e.wb = '0;
        e.wb.pc = p.pc;
        e.wb.ex_mem_out = load_value(addr, bt, p.is_signed);
        e.wb.is_wr_rd = p.is_wr_rd;
        e.wb.rd = p.rd;
        e.wb.csr_addr = p.csr_addr;
        e.check_data = ~store;
        e.is_mem = 1'b1;
        e.no_stall = no_stall;
        e.fwd_data = addr;
        if (store && !flush) begin
            apply_store(addr, bt, p.store_data);
        end
        send(p, e, flush);
    endtask

    task automatic issue_alu(input logic flush);
        execute_memory1_pass_t p;
        expect_t               e;
        u32_t                  r;
        r = rand_word();
        p = '0;
        p.pc = rand_word() & 32'hffff_fffc;
        p.pc_plus4 = p.pc + 32'd4;
        p.ex_out = rand_word();
        p.is_wr_rd = r[0];
        p.is_wr_rd_pc_plus4 = r[1];
        p.is_wr_csr = r[2];
        p.rd = r[12:8];
        p.csr_addr = r[27:16];
        e.wb = '0;
        e.wb.pc = p.pc;
        e.wb.ex_mem_out = r[1] ? p.pc_plus4 : p.ex_out;
        e.wb.is_wr_rd = p.is_wr_rd;
        e.wb.is_wr_rd_pc_plus4 = p.is_wr_rd_pc_plus4;
        e.wb.rd = p.rd;
        e.wb.is_wr_csr = p.is_wr_csr;
        e.wb.csr_addr = p.csr_addr;
        e.check_data = 1'b1;
        e.is_mem = 1'b0;
        e.no_stall = 1'b0;
        e.fwd_data = e.wb.ex_mem_out;
        send(p, e, flush);
    endtask

    // ############################################################
    // test sequence.
    // ############################################################

    initial begin
        u32_t       addr;
        u32_t       r;
        byte_type_t bt;
        seed = 84948;
        issued = 0;
        stall_cnt = 0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        ex_pass = '0;
        ex_pass.is_flush = 1'b1;
        excp_in = '0;
        is_flush = 1'b0;
        wait (rst_n === 1'b1);
        repeat (4) idle();

        repeat (100) begin
            rand_access(addr, bt);
            issue_mem(1'b1, addr, bt, 1'b0, 1'b0);
        end

        repeat (160) begin
            r = rand_word();
            rand_access(addr, bt);
            if (r[2:0] < 3'd4) begin
                issue_mem(1'b0, addr, bt, 1'b0, 1'b0);
            end else if (r[2:0] == 3'd4) begin
                issue_mem(1'b1, addr, bt, 1'b0, 1'b0);
            end else begin
                issue_alu(1'b0);
            end
        end

        // the second load finds the line that the first one brought in.
        repeat (20) begin
            rand_access(addr, bt);
            issue_mem(1'b0, addr, bt, 1'b0, 1'b0);
            issue_mem(1'b0, addr, bt, 1'b0, 1'b1);
        end

        // a flushed store is followed by a load that must still see the old data.
        repeat (10) begin
            drain();
            rand_access(addr, bt);
            issue_mem(1'b1, addr, bt, 1'b1, 1'b0);
            idle();
            issue_mem(1'b0, addr, bt, 1'b0, 1'b0);
            drain();
            issue_alu(1'b1);
        end

        drain();
        repeat (4) idle();
        if (exp_q.size() == 0 && issued > 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("error: %0d expected results never appeared", exp_q.size());
            stop_run();
        end
    end

endmodule

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := verilog.f
LOG       := sim.log

SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verilog.f
rtl/cpu_pkg.sv
rtl/pipe_pkg.sv
rtl/memory1.sv
rtl/dcache.sv
rtl/memory2.sv
rtl/mem_stage_top.sv
verif/tb_clock.sv
verif/tb_mem_stage.sv
